// ==== common/wu_consts.svh ====
`ifndef WU_CONSTS_SVH
`define WU_CONSTS_SVH

// Vector length, also the matrix side
`define NEURON_NUM 5
// Row index, wide enough for NEURON_NUM rows
`define ROW_IDX_WIDTH 3

// Unsigned activation cell
`define ACTIVATION_WIDTH 9
// Signed delta cell
`define DELTA_CELL_WIDTH 12
// Signed weight cell
`define WEIGHT_CELL_WIDTH 16

// Right shift applied to every product
`define FRACTION_WIDTH 0

// Zero-extended activation times signed delta
`define PRODUCT_WIDTH (`ACTIVATION_WIDTH + `DELTA_CELL_WIDTH + 1)
// Weight minus product, one guard bit
`define DIFF_WIDTH (`PRODUCT_WIDTH + 1)

`endif

// ==== common/wu_pkg.sv ====
`include "wu_consts.svh"

package wu_pkg;

    // Activations, element 0 in the low bits
    typedef logic [`NEURON_NUM-1:0][`ACTIVATION_WIDTH-1:0] act_vec_t;

    // Delta cells, read back through $signed per cell
    typedef logic [`NEURON_NUM-1:0][`DELTA_CELL_WIDTH-1:0] delta_vec_t;

    // One weight row, column 0 in the low bits
    typedef logic [`NEURON_NUM-1:0][`WEIGHT_CELL_WIDTH-1:0] weight_row_t;

    // Whole matrix, row i column j at flat index i*NEURON_NUM+j
    typedef weight_row_t [`NEURON_NUM-1:0] weight_mat_t;

    // Scaled products of one row
    typedef logic [`NEURON_NUM-1:0][`PRODUCT_WIDTH-1:0] prod_row_t;

    // Row handed to the datapath this cycle
    typedef struct packed {
        logic                      valid;
        logic [`ROW_IDX_WIDTH-1:0] row;
    } row_issue_t;

    // Tag that travels with a row through the pipeline
    typedef struct packed {
        logic                      valid;
        logic [`ROW_IDX_WIDTH-1:0] row;
        logic                      last;
    } row_stage_t;

endpackage

// ==== weight_updater/update_control.sv ====
`timescale 1ns/1ps
`include "wu_consts.svh"

module update_control (
    input  logic               clk,
    input  logic               rst,
    input  logic               a_valid,
    input  logic               delta_valid,
    input  logic               w_valid,
    input  logic               result_ready,
    output logic               a_ready,
    output logic               delta_ready,
    output logic               w_ready,
    output logic               result_valid,
    output logic               error,
    output logic               a_load,
    output logic               delta_load,
    output logic               w_load,
    output wu_pkg::row_issue_t issue,
    input  wu_pkg::row_stage_t stage2,
    input  logic               row_overflow
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_DRAIN,
        S_PRESENT
    } state_t;

    state_t                    state;
    logic [`ROW_IDX_WIDTH-1:0] row_cnt;
    logic                      last_issue;

    // Operands already taken this round
    logic cap_a;
    logic cap_delta;
    logic cap_w;
    logic all_in;

    // Sticky saturation flag
    logic error_q;

    //////////////////////////////////////////////////
    // Handshakes
    //////////////////////////////////////////////////

    // Each channel open only while idle and not yet taken
    assign a_ready     = (state == S_IDLE) && !cap_a;
    assign delta_ready = (state == S_IDLE) && !cap_delta;
    assign w_ready     = (state == S_IDLE) && !cap_w;

    assign a_load     = a_valid && a_ready;
    assign delta_load = delta_valid && delta_ready;
    assign w_load     = w_valid && w_ready;

    // Counting this cycle's transfers too
    assign all_in = (cap_a || a_load) && (cap_delta || delta_load) && (cap_w || w_load);

    assign result_valid = (state == S_PRESENT);
    assign error        = error_q;

    assign last_issue = (row_cnt == `ROW_IDX_WIDTH'(`NEURON_NUM - 1));

    always_comb begin
        issue.valid = (state == S_ISSUE);
        issue.row   = row_cnt;
    end

    //////////////////////////////////////////////////
    // Round sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            row_cnt   <= '0;
            cap_a     <= 1'b0;
            cap_delta <= 1'b0;
            cap_w     <= 1'b0;
            error_q   <= 1'b0;
        end else begin
            cap_a     <= cap_a || a_load;
            cap_delta <= cap_delta || delta_load;
            cap_w     <= cap_w || w_load;
            // Only set while rows drain through stage 2
            error_q   <= error_q || row_overflow;
            case (state)
                S_IDLE: begin
                    if (all_in) begin
                        state   <= S_ISSUE;
                        row_cnt <= '0;
                    end
                end
                S_ISSUE: begin
                    // One row per cycle
                    row_cnt <= row_cnt + 1'b1;
                    if (last_issue) begin
                        state <= S_DRAIN;
                    end
                end
                S_DRAIN: begin
                    // Last row written back this edge
                    if (stage2.valid && stage2.last) begin
                        state <= S_PRESENT;
                    end
                end
                S_PRESENT: begin
                    // Result taken, open the next round
                    if (result_ready) begin
                        state     <= S_IDLE;
                        cap_a     <= 1'b0;
                        cap_delta <= 1'b0;
                        cap_w     <= 1'b0;
                        error_q   <= 1'b0;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== weight_updater/operand_store.sv ====
`timescale 1ns/1ps
`include "wu_consts.svh"

module operand_store (
    input  logic                                clk,
    input  wu_pkg::act_vec_t                    a,
    input  wu_pkg::delta_vec_t                  delta,
    input  logic                                a_load,
    input  logic                                delta_load,
    input  wu_pkg::row_issue_t                  row_sel,
    output wu_pkg::act_vec_t                    a_held,
    output logic signed [`DELTA_CELL_WIDTH-1:0] delta_cell
);
    import wu_pkg::*;

    // Whole delta vector stays local
    delta_vec_t delta_held;

    // Activations, shared by every row
    always_ff @(posedge clk) begin
        if (a_load) begin
            a_held <= a;
        end
    end

    always_ff @(posedge clk) begin
        if (delta_load) begin
            delta_held <= delta;
        end
    end

    // Row i of the update scales by delta[i]
    assign delta_cell = $signed(delta_held[row_sel.row]);

endmodule

// ==== weight_updater/weight_matrix_buffer.sv ====
`timescale 1ns/1ps

module weight_matrix_buffer (
    input  logic                clk,
    input  wu_pkg::weight_mat_t w,
    input  logic                w_load,
    input  wu_pkg::row_issue_t  rd,
    output wu_pkg::weight_row_t rd_row,
    input  wu_pkg::row_stage_t  wr,
    input  wu_pkg::weight_row_t wr_row,
    output wu_pkg::weight_mat_t matrix
);
    import wu_pkg::*;

    // Matrix storage, old weights then updated rows
    weight_mat_t mat;

    //////////////////////////////////////////////////
    // Write side
    //////////////////////////////////////////////////

    // Full load only in idle, row writes only mid-update
    always_ff @(posedge clk) begin
        if (w_load) begin
            mat <= w;
        end else if (wr.valid) begin
            mat[wr.row] <= wr_row;
        end
    end

    //////////////////////////////////////////////////
    // Read side
    //////////////////////////////////////////////////

    // Issued row, read combinationally
    // Its write-back lands three edges later, never the same row
    assign rd_row = mat[rd.row];

    // Held contents are the result once the last row lands
    assign matrix = mat;

endmodule

// ==== weight_updater/row_product.sv ====
`timescale 1ns/1ps
`include "wu_consts.svh"

module row_product (
    input  logic                               clk,
    input  logic                               rst,
    input  wu_pkg::row_issue_t                 issue,
    input  wu_pkg::act_vec_t                   a_held,
    input  logic signed [`DELTA_CELL_WIDTH-1:0] delta_cell,
    input  wu_pkg::weight_row_t                rd_row,
    output wu_pkg::prod_row_t                  products,
    output wu_pkg::weight_row_t                old_row,
    output wu_pkg::row_stage_t                 stage1
);
    import wu_pkg::*;

    // Products before the register
    prod_row_t prod_d;

    // One multiplier per column
    for (genvar j = 0; j < `NEURON_NUM; j++) begin : g_cell
        logic signed [`PRODUCT_WIDTH-1:0] prod_full;

        // Activation zero-extended so it stays positive
        assign prod_full = $signed({1'b0, a_held[j]}) * delta_cell;
        // Arithmetic shift keeps the sign
        assign prod_d[j] = prod_full >>> `FRACTION_WIDTH;
    end

    // Row tag
    always_ff @(posedge clk) begin
        if (rst) begin
            stage1 <= '0;
        end else begin
            stage1.valid <= issue.valid;
            stage1.row   <= issue.row;
            stage1.last  <= (issue.row == `ROW_IDX_WIDTH'(`NEURON_NUM - 1));
        end
    end

    // Payload, only on an issued row
    always_ff @(posedge clk) begin
        if (issue.valid) begin
            products <= prod_d;
            old_row  <= rd_row;
        end
    end

endmodule

// ==== weight_updater/row_subtract_sat.sv ====
`timescale 1ns/1ps
`include "wu_consts.svh"

module row_subtract_sat (
    input  logic                clk,
    input  logic                rst,
    input  wu_pkg::prod_row_t   products,
    input  wu_pkg::weight_row_t old_row,
    input  wu_pkg::row_stage_t  stage1,
    output wu_pkg::weight_row_t new_row,
    output wu_pkg::row_stage_t  stage2,
    output logic                row_overflow
);
    import wu_pkg::*;

    // Clamped row and per-cell clamp flags
    weight_row_t             row_d;
    logic [`NEURON_NUM-1:0]  cell_ovf;

    for (genvar j = 0; j < `NEURON_NUM; j++) begin : g_cell
        logic signed [`DIFF_WIDTH-1:0] diff;
        logic                          all_ones;
        logic                          all_zeros;

        // Full width, cannot wrap
        assign diff = $signed(old_row[j]) - $signed(products[j]);

        // Fits only if the bits above the weight sign match it
        assign all_ones  = &diff[`DIFF_WIDTH-1:`WEIGHT_CELL_WIDTH-1];
        assign all_zeros = ~|diff[`DIFF_WIDTH-1:`WEIGHT_CELL_WIDTH-1];
        assign cell_ovf[j] = !(all_ones || all_zeros);

        // Negative overflow to min, positive to max
        assign row_d[j] = !cell_ovf[j] ? diff[`WEIGHT_CELL_WIDTH-1:0] :
                          diff[`DIFF_WIDTH-1] ? {1'b1, {(`WEIGHT_CELL_WIDTH-1){1'b0}}} :
                                                {1'b0, {(`WEIGHT_CELL_WIDTH-1){1'b1}}};
    end

    // Tag and flag
    always_ff @(posedge clk) begin
        if (rst) begin
            stage2       <= '0;
            row_overflow <= 1'b0;
        end else begin
            stage2       <= stage1;
            row_overflow <= stage1.valid && (|cell_ovf);
        end
    end

    // Updated row for write-back
    always_ff @(posedge clk) begin
        if (stage1.valid) begin
            new_row <= row_d;
        end
    end

endmodule

// ==== weight_updater/weight_updater.sv ====
`timescale 1ns/1ps
`include "wu_consts.svh"

module weight_updater (
    input  logic                clk,
    input  logic                rst,
    input  wu_pkg::act_vec_t    a,
    input  logic                a_valid,
    output logic                a_ready,
    input  wu_pkg::delta_vec_t  delta,
    input  logic                delta_valid,
    output logic                delta_ready,
    input  wu_pkg::weight_mat_t w,
    input  logic                w_valid,
    output logic                w_ready,
    output wu_pkg::weight_mat_t result,
    output logic                result_valid,
    input  logic                result_ready,
    output logic                error
);
    import wu_pkg::*;

    //////////////////////////////////////////////////
    // Internal wires
    //////////////////////////////////////////////////

    // Capture strobes
    logic a_load;
    logic delta_load;
    logic w_load;

    // Issued row and its operands
    row_issue_t                          issue;
    act_vec_t                            a_held;
    logic signed [`DELTA_CELL_WIDTH-1:0] delta_cell;
    weight_row_t                         rd_row;

    // Stage 1 outputs
    prod_row_t   products;
    weight_row_t old_row;
    row_stage_t  stage1;

    // Stage 2 outputs, also the write-back port
    weight_row_t new_row;
    row_stage_t  stage2;
    logic        row_overflow;

    //////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////

    update_control control_i (
        .clk         (clk),
        .rst         (rst),
        .a_valid     (a_valid),
        .delta_valid (delta_valid),
        .w_valid     (w_valid),
        .result_ready(result_ready),
        .a_ready     (a_ready),
        .delta_ready (delta_ready),
        .w_ready     (w_ready),
        .result_valid(result_valid),
        .error       (error),
        .a_load      (a_load),
        .delta_load  (delta_load),
        .w_load      (w_load),
        .issue       (issue),
        .stage2      (stage2),
        .row_overflow(row_overflow)
    );

    //////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////

    operand_store operands_i (
        .clk       (clk),
        .a         (a),
        .delta     (delta),
        .a_load    (a_load),
        .delta_load(delta_load),
        .row_sel   (issue),
        .a_held    (a_held),
        .delta_cell(delta_cell)
    );

    // Matrix contents go straight out as the result
    weight_matrix_buffer buffer_i (
        .clk   (clk),
        .w     (w),
        .w_load(w_load),
        .rd    (issue),
        .rd_row(rd_row),
        .wr    (stage2),
        .wr_row(new_row),
        .matrix(result)
    );

    row_product product_i (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .a_held    (a_held),
        .delta_cell(delta_cell),
        .rd_row    (rd_row),
        .products  (products),
        .old_row   (old_row),
        .stage1    (stage1)
    );

    row_subtract_sat subtract_i (
        .clk         (clk),
        .rst         (rst),
        .products    (products),
        .old_row     (old_row),
        .stage1      (stage1),
        .new_row     (new_row),
        .stage2      (stage2),
        .row_overflow(row_overflow)
    );

endmodule

// ==== test/weight_updater_assert.sv ====
`timescale 1ns/1ps
`include "wu_consts.svh"

module weight_updater_assert (
    input logic                clk,
    input logic                rst,
    input wu_pkg::weight_mat_t result,
    input logic                result_valid,
    input logic                result_ready,
    input logic                error,
    input logic                a_ready,
    input logic                delta_ready,
    input logic                w_ready,
    input logic                a_load,
    input logic                delta_load,
    input logic                w_load
);

    logic any_ready;
    logic any_load;

    assign any_ready = a_ready || delta_ready || w_ready;
    assign any_load  = a_load || delta_load || w_load;

    //////////////////////////////////////////////////
    // Result channel
    //////////////////////////////////////////////////

    // Stalled result keeps data and flag
    hold_result: assert property (@(posedge clk) disable iff (rst)
        result_valid && !result_ready |=> $stable(result) && $stable(error))
        else $error("result or error changed while result_ready was low");

    // Inputs closed while a result is presented
    inputs_closed: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> !any_ready)
        else $error("input ready high while result_valid was high");

    // Last operand taken means a load, then every channel closed
    result_latency: assert property (@(posedge clk) disable iff (rst)
        any_load ##1 !any_ready |-> ##(`NEURON_NUM + 2) $rose(result_valid))
        else $error("result_valid did not rise at the expected cycle");

endmodule

bind weight_updater weight_updater_assert assert_i (
    .clk         (clk),
    .rst         (rst),
    .result      (result),
    .result_valid(result_valid),
    .result_ready(result_ready),
    .error       (error),
    .a_ready     (a_ready),
    .delta_ready (delta_ready),
    .w_ready     (w_ready),
    .a_load      (a_load),
    .delta_load  (delta_load),
    .w_load      (w_load)
);

// ==== test/tb_weight_updater.sv ====
`timescale 1ns/1ps
`include "wu_consts.svh"

module tb_weight_updater;
    import wu_pkg::*;

    // Cycles from last acceptance to result_valid
    localparam int     LATENCY    = `NEURON_NUM + 2;
    localparam int     WAIT_LIMIT = 50;
    localparam longint W_MAX      = 2 ** (`WEIGHT_CELL_WIDTH - 1) - 1;
    localparam longint W_MIN      = -(2 ** (`WEIGHT_CELL_WIDTH - 1));

    logic        clk;
    logic        rst;
    act_vec_t    a;
    logic        a_valid;
    logic        a_ready;
    delta_vec_t  delta;
    logic        delta_valid;
    logic        delta_ready;
    weight_mat_t w;
    logic        w_valid;
    logic        w_ready;
    weight_mat_t result;
    logic        result_valid;
    logic        result_ready;
    logic        error;

    // Bookkeeping
    int          errors;
    int          checks;
    int          cycle_cnt = 0;
    int          last_accept;
    string       test_name;
    logic [15:0] lfsr_state;

    // Reference model output
    weight_mat_t exp_mat;
    logic        exp_err;

    weight_updater weight_updater_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Free-running cycle count for latency
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic check(input string what, input logic [511:0] expected,
                         input logic [511:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    // Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One step per bit taken
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Old weight minus the shifted product a[j] * delta[i] then clamped
    task automatic model_update(input act_vec_t av, input delta_vec_t dv,
                                input weight_mat_t wv);
        longint prod;
        longint diff;
        exp_err = 1'b0;
        for (int i = 0; i < `NEURON_NUM; i++) begin
            for (int j = 0; j < `NEURON_NUM; j++) begin
                prod = longint'(av[j]) * longint'($signed(dv[i]));
                prod = prod >>> `FRACTION_WIDTH;
                diff = longint'($signed(wv[i][j])) - prod;
                if (diff > W_MAX) begin
                    diff    = W_MAX;
                    exp_err = 1'b1;
                end else if (diff < W_MIN) begin
                    diff    = W_MIN;
                    exp_err = 1'b1;
                end
                exp_mat[i][j] = diff[`WEIGHT_CELL_WIDTH-1:0];
            end
        end
    endtask

    task automatic random_operands();
        logic [31:0] r;
        for (int i = 0; i < `NEURON_NUM; i++) begin
            rand_bits(`ACTIVATION_WIDTH, r);
            a[i] = r[`ACTIVATION_WIDTH-1:0];
            rand_bits(`DELTA_CELL_WIDTH, r);
            delta[i] = r[`DELTA_CELL_WIDTH-1:0];
            for (int j = 0; j < `NEURON_NUM; j++) begin
                rand_bits(`WEIGHT_CELL_WIDTH, r);
                w[i][j] = r[`WEIGHT_CELL_WIDTH-1:0];
            end
        end
    endtask

    // a = 10..50, delta = 1..5, w = 0..24
    task automatic load_reference();
        for (int i = 0; i < `NEURON_NUM; i++) begin
            a[i]     = `ACTIVATION_WIDTH'(10 * (i + 1));
            delta[i] = `DELTA_CELL_WIDTH'(i + 1);
            for (int j = 0; j < `NEURON_NUM; j++) begin
                w[i][j] = `WEIGHT_CELL_WIDTH'(i * `NEURON_NUM + j);
            end
        end
    endtask

    // Channel of step k in bits 2k+1:2k
    // Channel codes are a 0, delta 1 and w 2
    function automatic logic [5:0] order_of(input int p);
        case (p)
            0:       return {2'd2, 2'd1, 2'd0};
            1:       return {2'd1, 2'd2, 2'd0};
            2:       return {2'd2, 2'd0, 2'd1};
            3:       return {2'd0, 2'd2, 2'd1};
            4:       return {2'd1, 2'd0, 2'd2};
            default: return {2'd0, 2'd1, 2'd2};
        endcase
    endfunction

    function automatic logic ready_of(input int ch);
        case (ch)
            0:       return a_ready;
            1:       return delta_ready;
            default: return w_ready;
        endcase
    endfunction

    task automatic set_valid(input int ch, input logic v);
        case (ch)
            0:       a_valid = v;
            1:       delta_valid = v;
            default: w_valid = v;
        endcase
    endtask

    //////////////////////////////////////////////////
    // Handshake tasks
    //////////////////////////////////////////////////

    // Starts and ends on a falling edge
    task automatic send_operands(input logic [5:0] order, input logic [5:0] gaps);
        int ch;
        int waited;
        for (int k = 0; k < 3; k++) begin
            ch = int'(order[2*k +: 2]);
            repeat (gaps[2*k +: 2]) @(negedge clk);
            set_valid(ch, 1'b1);
            waited = 0;
            while (!ready_of(ch) && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (!ready_of(ch)) begin
                errors++;
                $display("ERROR %s: channel %0d never became ready", test_name, ch);
            end
            // Transfer on the coming rising edge
            last_accept = cycle_cnt + 1;
            @(negedge clk);
            set_valid(ch, 1'b0);
            check("ready low after own accept", 1'b0, ready_of(ch));
        end
    endtask

    task automatic wait_result();
        int waited;
        waited = 0;
        while (!result_valid && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!result_valid) begin
            errors++;
            $display("ERROR %s: result_valid never rose", test_name);
        end else begin
            check("latency", LATENCY, cycle_cnt - last_accept);
        end
    endtask

    task automatic check_result();
        check("result", exp_mat, result);
        check("error", exp_err, error);
    endtask

    // Transfer and check that the next round opens
    task automatic take_result();
        result_ready = 1'b1;
        @(negedge clk);
        result_ready = 1'b0;
        check("result_valid after transfer", 1'b0, result_valid);
        check("readies after transfer", 3'b111, {a_ready, delta_ready, w_ready});
        check("error after transfer", 1'b0, error);
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_reference();
        test_name = "reference";
        load_reference();
        model_update(a, delta, w);
        send_operands(order_of(0), 6'd0);
        wait_result();
        check_result();
        take_result();
    endtask

    // Every order with random idle gaps
    task automatic test_order();
        logic [31:0] r;
        test_name = "order";
        for (int p = 0; p < 6; p++) begin
            random_operands();
            model_update(a, delta, w);
            rand_bits(6, r);
            send_operands(order_of(p), r[5:0]);
            wait_result();
            check_result();
            take_result();
        end
    endtask

    task automatic test_saturation();
        test_name = "saturation";
        random_operands();
        for (int j = 0; j < `NEURON_NUM; j++) begin
            a[j] = `ACTIVATION_WIDTH'(500 + j);
        end
        // Rows 0 and 3 push down, rows 1 and 2 push up
        delta[0] = `DELTA_CELL_WIDTH'(2047);
        delta[1] = `DELTA_CELL_WIDTH'(-2048);
        delta[2] = `DELTA_CELL_WIDTH'(-1800);
        delta[3] = `DELTA_CELL_WIDTH'(1900);
        delta[4] = `DELTA_CELL_WIDTH'(3);
        model_update(a, delta, w);
        send_operands(order_of(3), 6'd0);
        wait_result();
        check_result();
        check("row 0 at min", 16'h8000, result[0][0]);
        check("row 1 at max", 16'h7fff, result[1][0]);
        check("error set", 1'b1, error);
        take_result();
        // Clean round afterwards
        load_reference();
        model_update(a, delta, w);
        send_operands(order_of(1), 6'd0);
        wait_result();
        check_result();
        take_result();
    endtask

    task automatic test_backpressure();
        logic [31:0] r;
        test_name = "backpressure";
        random_operands();
        model_update(a, delta, w);
        send_operands(order_of(5), 6'd0);
        wait_result();
        check_result();
        // Fresh operands offered while stalled must not enter
        random_operands();
        a_valid     = 1'b1;
        delta_valid = 1'b1;
        w_valid     = 1'b1;
        rand_bits(4, r);
        repeat (int'(r[3:0]) + 2) begin
            @(negedge clk);
            check("result held", exp_mat, result);
            check("error held", exp_err, error);
            check("result_valid held", 1'b1, result_valid);
            check("readies low", 3'b000, {a_ready, delta_ready, w_ready});
        end
        a_valid     = 1'b0;
        delta_valid = 1'b0;
        w_valid     = 1'b0;
        take_result();
    endtask

    task automatic test_reset();
        test_name = "reset";
        random_operands();
        send_operands(order_of(2), 6'd0);
        // Rows being issued now
        repeat (2) @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        check("result_valid after reset", 1'b0, result_valid);
        check("readies after reset", 3'b111, {a_ready, delta_ready, w_ready});
        repeat (LATENCY + 2) begin
            @(negedge clk);
            check("no stray result", 1'b0, result_valid);
        end
        load_reference();
        model_update(a, delta, w);
        send_operands(order_of(4), 6'd0);
        wait_result();
        check_result();
        take_result();
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        errors       = 0;
        checks       = 0;
        lfsr_state   = 16'd44;
        test_name    = "startup";
        rst          = 1'b1;
        a            = '0;
        a_valid      = 1'b0;
        delta        = '0;
        delta_valid  = 1'b0;
        w            = '0;
        w_valid      = 1'b0;
        result_ready = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        check("readies after reset", 3'b111, {a_ready, delta_ready, w_ready});
        check("result_valid after reset", 1'b0, result_valid);
        test_reference();
        test_order();
        test_saturation();
        test_backpressure();
        test_reset();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+common
common/wu_pkg.sv
weight_updater/update_control.sv
weight_updater/operand_store.sv
weight_updater/weight_matrix_buffer.sv
weight_updater/row_product.sv
weight_updater/row_subtract_sat.sv
weight_updater/weight_updater.sv
test/weight_updater_assert.sv
test/tb_weight_updater.sv

// ==== Makefile ====
TOP  := tb_weight_updater
SRCS := $(filter-out +%,$(shell cat flist.f))

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
obj_dir/V$(TOP): flist.f $(SRCS) common/wu_consts.svh
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP)

# Pass only if the log holds the pass line
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
